/* logic/adc_rx_pkg.sv */
package adc_rx_pkg;

   // --------------------
   // widths
   localparam int ADC_W       = 14;   // one ADC sample
   localparam int BUS_AW      = 32;
   localparam int BUS_DW      = 32;
   localparam int BUS_SW      = 4;    // byte selects
   localparam int NUM_REGIONS = 8;
   localparam int REGION_LSB  = 20;   // region select field
   localparam int REGION_MSB  = 22;
   localparam int REG_OFS_W   = 8;    // offset inside a region
   localparam int EXP_W       = 8;
   localparam int LED_W       = 8;

   localparam logic [ADC_W-1:0] ADC_MID    = {1'b1, {(ADC_W-1){1'b0}}};  // offset binary zero
   localparam logic [ADC_W-1:0] ADC_TC_MIN = {1'b1, {(ADC_W-1){1'b0}}};  // most negative
   localparam logic [ADC_W-1:0] ADC_TC_MAX = {1'b0, {(ADC_W-1){1'b1}}};  // most positive

   // --------------------
   // region map
   localparam logic [BUS_DW-1:0]      HK_ID      = 32'h5241_0e14;  // board id word
   localparam int                     RGN_HK     = 0;
   localparam int                     RGN_FE     = 1;
   localparam logic [NUM_REGIONS-1:0] RGN_MAPPED = (1 << RGN_HK) | (1 << RGN_FE);

   // housekeeping offsets
   localparam logic [REG_OFS_W-1:0] HK_ID_OFS   = 8'h00;
   localparam logic [REG_OFS_W-1:0] HK_PDIR_OFS = 8'h10;
   localparam logic [REG_OFS_W-1:0] HK_NDIR_OFS = 8'h14;
   localparam logic [REG_OFS_W-1:0] HK_POUT_OFS = 8'h18;
   localparam logic [REG_OFS_W-1:0] HK_NOUT_OFS = 8'h1C;
   localparam logic [REG_OFS_W-1:0] HK_PIN_OFS  = 8'h20;
   localparam logic [REG_OFS_W-1:0] HK_NIN_OFS  = 8'h24;
   localparam logic [REG_OFS_W-1:0] HK_LED_OFS  = 8'h30;

   // front-end offsets
   localparam logic [REG_OFS_W-1:0] FE_NEG_OFS  = 8'h00;  // [0] ch a, [1] ch b
   localparam logic [REG_OFS_W-1:0] FE_SMPA_OFS = 8'h04;
   localparam logic [REG_OFS_W-1:0] FE_SMPB_OFS = 8'h08;

   // --------------------
   // types
   typedef struct packed {
      logic [BUS_AW-1:0] addr;
      logic [BUS_DW-1:0] wdata;
      logic [BUS_SW-1:0] sel;    // write byte lanes
      logic              wen;    // single cycle strobe
      logic              ren;
   } sys_req_t;

   typedef struct packed {
      logic [BUS_DW-1:0] rdata;
      logic              err;
      logic              ack;    // one cycle after strobe
   } sys_rsp_t;

   typedef struct packed {
      logic signed [ADC_W-1:0] a;
      logic signed [ADC_W-1:0] b;
   } adc_pair_t;

   typedef struct packed {
      logic [EXP_W-1:0] p;
      logic [EXP_W-1:0] n;
   } exp_port_t;

   // replace only the selected byte lanes of a register word
   function automatic logic [BUS_DW-1:0] byte_merge(input logic [BUS_DW-1:0] old_w,
                                                    input logic [BUS_DW-1:0] new_w,
                                                    input logic [BUS_SW-1:0] sel);
      logic [BUS_DW-1:0] res;
      res = old_w;
      for (int i = 0; i < BUS_SW; i++) begin
         if (sel[i]) begin
            res[i*8 +: 8] = new_w[i*8 +: 8];
         end
      end
      return res;
   endfunction

endpackage

/* logic/adc_frontend.sv */
`timescale 1ns/10ps

module adc_frontend import adc_rx_pkg::*; (
   input  logic             adc_clk,
   input  logic             arst_n_i,
   input  logic [ADC_W-1:0] adc_a_raw_i,    // offset binary
   input  logic [ADC_W-1:0] adc_b_raw_i,
   input  logic [1:0]       neg_i,          // [0] ch a, [1] ch b
   output adc_pair_t        smp_o
);

   logic [ADC_W-1:0] raw_a_q;   // stage 1
   logic [ADC_W-1:0] raw_b_q;
   adc_pair_t        smp_q;     // stage 2

   // offset binary to two's complement, optional negate
   function automatic logic signed [ADC_W-1:0] conv(input logic [ADC_W-1:0] raw,
                                                    input logic             neg);
      logic signed [ADC_W-1:0] tc;
      tc = {~raw[ADC_W-1], raw[ADC_W-2:0]};   // flip sign bit
      if (!neg) begin
         return tc;
      end
      if (tc == ADC_TC_MIN) begin
         return ADC_TC_MAX;   // -min does not fit, clip
      end
      return -tc;
   endfunction

   // --------------------
   // input register, edge 1
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         raw_a_q <= ADC_MID;   // midscale so first sample reads zero
         raw_b_q <= ADC_MID;
      end else begin
         raw_a_q <= adc_a_raw_i;
         raw_b_q <= adc_b_raw_i;
      end
   end

   // conversion register, edge 2
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         smp_q <= '0;
      end else begin
         smp_q.a <= conv(raw_a_q, neg_i[0]);
         smp_q.b <= conv(raw_b_q, neg_i[1]);
      end
   end

   assign smp_o = smp_q;

   // both pipeline stages come out of reset holding zero
   a_zero_after_rst: assert property (@(posedge adc_clk)
      $rose(arst_n_i) |=> smp_o == '0);

endmodule

/* logic/sys_bus_decoder.sv */
`timescale 1ns/10ps

module sys_bus_decoder import adc_rx_pkg::*; (
   input  logic     adc_clk,
   input  logic     arst_n_i,
   input  sys_req_t req_i,
   output sys_req_t rgn_req_o [NUM_REGIONS],   // strobes gated per region
   input  sys_rsp_t rgn_rsp_i [NUM_REGIONS],
   output sys_rsp_t rsp_o
);

   logic [REGION_MSB-REGION_LSB:0] rgn_idx;
   logic [NUM_REGIONS-1:0]         rgn_cs;      // one-hot select
   logic                           unm_ack_q;   // answer for empty regions
   sys_rsp_t                       sel_rsp;
   sys_rsp_t                       unm_rsp;

   assign rgn_idx = req_i.addr[REGION_MSB:REGION_LSB];

   always_comb begin
      rgn_cs          = '0;
      rgn_cs[rgn_idx] = 1'b1;
   end

   // --------------------
   // request fan-out
   always_comb begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
         rgn_req_o[i]     = req_i;
         rgn_req_o[i].wen = req_i.wen & rgn_cs[i];
         rgn_req_o[i].ren = req_i.ren & rgn_cs[i];
      end
   end

   // unmapped region answers ack + err itself
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         unm_ack_q <= 1'b0;
      end else begin
         unm_ack_q <= (req_i.wen | req_i.ren) & ~|(rgn_cs & RGN_MAPPED);
      end
   end

   assign unm_rsp = '{rdata: '0, err: unm_ack_q, ack: unm_ack_q};

   // --------------------
   // response and-or mux, addr still stable at ack
   always_comb begin
      sel_rsp = '0;
      for (int i = 0; i < NUM_REGIONS; i++) begin
         if (rgn_cs[i] && RGN_MAPPED[i]) begin
            sel_rsp = sel_rsp | rgn_rsp_i[i];
         end
      end
   end

   assign rsp_o = sel_rsp | unm_rsp;

   a_no_wen_ren: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      !(req_i.wen && req_i.ren));

   // every strobe is answered in the next cycle, by region or decoder
   a_ack_follows: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      (req_i.wen || req_i.ren) |=> rsp_o.ack);

   a_ack_has_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      rsp_o.ack |-> $past(req_i.wen || req_i.ren));

endmodule

/* logic/housekeeping_regs.sv */
`timescale 1ns/10ps

module housekeeping_regs import adc_rx_pkg::*; (
   input  logic             adc_clk,
   input  logic             arst_n_i,
   input  sys_req_t         req_i,
   output sys_rsp_t         rsp_o,
   output logic [LED_W-1:0] led_o,
   output exp_port_t        exp_dir_o,   // 1 = drive pin
   output exp_port_t        exp_out_o,
   input  exp_port_t        exp_in_i     // async pins
);

   logic [REG_OFS_W-1:0] ofs;
   logic [LED_W-1:0]     led_q;
   exp_port_t            dir_q;
   exp_port_t            out_q;
   exp_port_t            in_meta;       // sync stage 1
   exp_port_t            in_sync;       // sync stage 2
   logic [BUS_DW-1:0]    rd_mux;
   logic [BUS_DW-1:0]    rdata_q;
   logic                 ack_q;

   assign ofs = req_i.addr[REG_OFS_W-1:0];

   // --------------------
   // writable registers
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         led_q <= '0;
         dir_q <= '0;
         out_q <= '0;
      end else if (req_i.wen) begin
         case (ofs)
            HK_PDIR_OFS: dir_q.p <= EXP_W'(byte_merge(BUS_DW'(dir_q.p), req_i.wdata, req_i.sel));
            HK_NDIR_OFS: dir_q.n <= EXP_W'(byte_merge(BUS_DW'(dir_q.n), req_i.wdata, req_i.sel));
            HK_POUT_OFS: out_q.p <= EXP_W'(byte_merge(BUS_DW'(out_q.p), req_i.wdata, req_i.sel));
            HK_NOUT_OFS: out_q.n <= EXP_W'(byte_merge(BUS_DW'(out_q.n), req_i.wdata, req_i.sel));
            HK_LED_OFS:  led_q   <= LED_W'(byte_merge(BUS_DW'(led_q), req_i.wdata, req_i.sel));
            default: ;   // unknown offset ignored
         endcase
      end
   end

   // 2-flop input synchronizer
   always_ff @(posedge adc_clk) begin
      in_meta <= exp_in_i;
      in_sync <= in_meta;
   end

   // --------------------
   // read path
   always_comb begin
      case (ofs)
         HK_ID_OFS:   rd_mux = HK_ID;
         HK_PDIR_OFS: rd_mux = BUS_DW'(dir_q.p);
         HK_NDIR_OFS: rd_mux = BUS_DW'(dir_q.n);
         HK_POUT_OFS: rd_mux = BUS_DW'(out_q.p);
         HK_NOUT_OFS: rd_mux = BUS_DW'(out_q.n);
         HK_PIN_OFS:  rd_mux = BUS_DW'(in_sync.p);
         HK_NIN_OFS:  rd_mux = BUS_DW'(in_sync.n);
         HK_LED_OFS:  rd_mux = BUS_DW'(led_q);
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge adc_clk) begin
      rdata_q <= req_i.ren ? rd_mux : '0;
   end

   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_i.wen | req_i.ren;   // one cycle late
      end
   end

   assign rsp_o     = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
   assign led_o     = led_q;
   assign exp_dir_o = dir_q;
   assign exp_out_o = out_q;

   // master waits for ack before the next strobe
   a_ack_single: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      rsp_o.ack |=> !rsp_o.ack);

endmodule

/* logic/frontend_regs.sv */
`timescale 1ns/10ps

module frontend_regs import adc_rx_pkg::*; (
   input  logic       adc_clk,
   input  logic       arst_n_i,
   input  sys_req_t   req_i,
   output sys_rsp_t   rsp_o,
   input  adc_pair_t  smp_i,     // latest converted pair
   output logic [1:0] neg_o      // [0] ch a, [1] ch b
);

   logic [REG_OFS_W-1:0] ofs;
   logic [1:0]           neg_q;
   logic [BUS_DW-1:0]    rd_mux;
   logic [BUS_DW-1:0]    rdata_q;
   logic                 ack_q;

   assign ofs = req_i.addr[REG_OFS_W-1:0];

   // --------------------
   // negate control
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         neg_q <= '0;
      end else if (req_i.wen && ofs == FE_NEG_OFS) begin
         neg_q <= 2'(byte_merge(BUS_DW'(neg_q), req_i.wdata, req_i.sel));
      end
   end

   // --------------------
   // readback, samples sign extended
   always_comb begin
      case (ofs)
         FE_NEG_OFS:  rd_mux = BUS_DW'(neg_q);
         FE_SMPA_OFS: rd_mux = {{(BUS_DW-ADC_W){smp_i.a[ADC_W-1]}}, smp_i.a};
         FE_SMPB_OFS: rd_mux = {{(BUS_DW-ADC_W){smp_i.b[ADC_W-1]}}, smp_i.b};
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge adc_clk) begin
      rdata_q <= req_i.ren ? rd_mux : '0;   // pair taken at the read strobe
   end

   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_i.wen | req_i.ren;
      end
   end

   assign rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
   assign neg_o = neg_q;

endmodule

/* logic/radar_adc_top.sv */
`timescale 1ns/10ps

module radar_adc_top import adc_rx_pkg::*; (
   input  logic             adc_clk,
   input  logic             arst_n_i,
   input  logic [ADC_W-1:0] adc_dat_a_i,   // ch a, offset binary
   input  logic [ADC_W-1:0] adc_dat_b_i,   // ch b
   input  sys_req_t         sys_req_i,
   output sys_rsp_t         sys_rsp_o,
   output logic [LED_W-1:0] led_o,
   output exp_port_t        exp_dir_o,
   output exp_port_t        exp_out_o,
   input  exp_port_t        exp_in_i
);

   logic [1:0] rst_sync;             // async assert, 2-flop release
   logic       rst_n;
   adc_pair_t  smp;
   logic [1:0] adc_neg;
   sys_req_t   rgn_req [NUM_REGIONS];
   wire sys_rsp_t rgn_rsp [NUM_REGIONS];

   // --------------------
   // reset synchronizer
   always_ff @(posedge adc_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign rst_n = rst_sync[1];

   // --------------------
   // analog front end
   adc_frontend u_adc_frontend (
      .adc_clk     (adc_clk),
      .arst_n_i    (rst_n),
      .adc_a_raw_i (adc_dat_a_i),
      .adc_b_raw_i (adc_dat_b_i),
      .neg_i       (adc_neg),
      .smp_o       (smp)
   );

   // --------------------
   // bus decoder, 8 regions on addr[22:20]
   sys_bus_decoder u_sys_bus_decoder (
      .adc_clk   (adc_clk),
      .arst_n_i  (rst_n),
      .req_i     (sys_req_i),
      .rgn_req_o (rgn_req),
      .rgn_rsp_i (rgn_rsp),
      .rsp_o     (sys_rsp_o)
   );

   for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_rgn_tie
      if (!RGN_MAPPED[g]) begin : g_unmapped
         assign rgn_rsp[g] = '0;   // decoder answers these
      end
   end

   housekeeping_regs u_housekeeping_regs (
      .adc_clk   (adc_clk),
      .arst_n_i  (rst_n),
      .req_i     (rgn_req[RGN_HK]),
      .rsp_o     (rgn_rsp[RGN_HK]),
      .led_o     (led_o),
      .exp_dir_o (exp_dir_o),
      .exp_out_o (exp_out_o),
      .exp_in_i  (exp_in_i)
   );

   frontend_regs u_frontend_regs (
      .adc_clk  (adc_clk),
      .arst_n_i (rst_n),
      .req_i    (rgn_req[RGN_FE]),
      .rsp_o    (rgn_rsp[RGN_FE]),
      .smp_i    (smp),
      .neg_o    (adc_neg)
   );

endmodule

/* verif/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------
// one strobe, then poll for ack
task automatic bus_access(input  logic [BUS_AW-1:0] addr,
                          input  logic [BUS_DW-1:0] wdata,
                          input  logic [BUS_SW-1:0] sel,
                          input  logic              wr,
                          output logic [BUS_DW-1:0] rdata,
                          output logic              err);
   int waited;
   @(posedge adc_clk);
   #1;
   sys_req.addr  = addr;             // held until ack
   sys_req.wdata = wdata;
   sys_req.sel   = sel;
   sys_req.wen   = wr;               // single cycle strobe
   sys_req.ren   = !wr;
   @(posedge adc_clk);
   #1;
   sys_req.wen = 1'b0;
   sys_req.ren = 1'b0;
   waited      = 0;
   while (!sys_rsp.ack && waited < ACK_TIMEOUT) begin
      @(posedge adc_clk);
      #1;
      waited++;
   end
   if (sys_rsp.ack) begin
      rdata = sys_rsp.rdata;         // valid with ack
      err   = sys_rsp.err;
   end else begin
      err_cnt++;
      $display("no acknowledge from bus at address %h", addr);
      rdata = '0;
      err   = 1'b1;
   end
endtask

task automatic bus_write(input  logic [BUS_AW-1:0] addr,
                         input  logic [BUS_DW-1:0] wdata,
                         input  logic [BUS_SW-1:0] sel,
                         output logic              err);
   logic [BUS_DW-1:0] unused_rdata;
   bus_access(addr, wdata, sel, 1'b1, unused_rdata, err);
endtask

task automatic bus_read(input  logic [BUS_AW-1:0] addr,
                        output logic [BUS_DW-1:0] rdata,
                        output logic              err);
   bus_access(addr, '0, '0, 1'b0, rdata, err);
endtask

`endif

/* verif/tb_radar_adc_top.sv */
`timescale 1ns/10ps

module tb_radar_adc_top import adc_rx_pkg::*; ();

   localparam int CLK_HALF    = 4;    // 8 ns period
   localparam int ACK_TIMEOUT = 20;   // cycles
   localparam int CMP_TIMEOUT = 10;

   logic             adc_clk;
   logic             arst_n_i;
   logic [ADC_W-1:0] adc_dat_a;
   logic [ADC_W-1:0] adc_dat_b;
   sys_req_t         sys_req;
   sys_rsp_t         sys_rsp;
   logic [LED_W-1:0] led;
   exp_port_t        exp_dir;
   exp_port_t        exp_out;
   exp_port_t        exp_in;

   integer      seed    = 32'h4b1c;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   string       cmp_name_q [$];      // pending checks
   logic [31:0] cmp_exp_q [$];
   logic [31:0] cmp_act_q [$];
   logic [7:0]  hk_model [5];        // pdir, ndir, pout, nout, led

   `include "tb_bus_tasks.svh"

   initial begin
      adc_clk = 1'b0;
      forever #CLK_HALF adc_clk = ~adc_clk;
   end

   radar_adc_top u_radar_adc_top (
      .adc_clk     (adc_clk),
      .arst_n_i    (arst_n_i),
      .adc_dat_a_i (adc_dat_a),
      .adc_dat_b_i (adc_dat_b),
      .sys_req_i   (sys_req),
      .sys_rsp_o   (sys_rsp),
      .led_o       (led),
      .exp_dir_o   (exp_dir),
      .exp_out_o   (exp_out),
      .exp_in_i    (exp_in)
   );

   // --------------------
   // expected values
   function automatic logic [31:0] ref_sample(input logic [ADC_W-1:0] raw, input logic neg);
      int val;
      val = int'(raw) - (1 << (ADC_W-1));   // offset binary to signed
      if (neg) begin
         // most negative has no positive twin, clip to max
         val = (val == -(1 << (ADC_W-1))) ? (1 << (ADC_W-1)) - 1 : -val;
      end
      return val;                           // 32 bit sign extended
   endfunction

   function automatic logic [31:0] lane_merge(input logic [31:0] old_v,
                                              input logic [31:0] new_v,
                                              input logic [3:0]  sel);
      logic [31:0] mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old_v & ~mask) | (new_v & mask);
   endfunction

   function automatic logic [BUS_AW-1:0] rgn_addr(input int rgn, input logic [7:0] ofs);
      return (BUS_AW'(rgn) << REGION_LSB) | BUS_AW'(ofs);
   endfunction

   function automatic logic [7:0] hk_reg_ofs(input int idx);
      case (idx)
         0:       return HK_PDIR_OFS;
         1:       return HK_NDIR_OFS;
         2:       return HK_POUT_OFS;
         3:       return HK_NOUT_OFS;
         default: return HK_LED_OFS;
      endcase
   endfunction

   task automatic queue_check(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      cmp_name_q.push_back(name);
      cmp_exp_q.push_back(exp_v);
      cmp_act_q.push_back(act_v);
   endtask

   task automatic check_hk_outputs();
      queue_check("led_o", 32'(hk_model[4]), 32'(led));
      queue_check("exp_dir_o", 32'({hk_model[0], hk_model[1]}), 32'(exp_dir));   // p is msb half
      queue_check("exp_out_o", 32'({hk_model[2], hk_model[3]}), 32'(exp_out));
   endtask

   // --------------------
   // compare process, drains at each edge
   always @(posedge adc_clk) begin : compare_proc
      string       name;
      logic [31:0] exp_v;
      logic [31:0] act_v;
      while (cmp_name_q.size() > 0) begin
         name  = cmp_name_q.pop_front();
         exp_v = cmp_exp_q.pop_front();
         act_v = cmp_act_q.pop_front();
         chk_cnt++;
         assert (act_v === exp_v) else begin
            err_cnt++;
            $display("Fail %s expected %h actual %h", name, exp_v, act_v);
         end
      end
   end

   initial begin : stimulus
      logic [31:0]      rdata;
      logic [31:0]      wdata;
      logic             err;
      logic [3:0]       sel;
      logic [1:0]       neg;
      logic [ADC_W-1:0] raw_a;
      logic [ADC_W-1:0] raw_b;
      int               idx;
      int               waited;

      arst_n_i  = 1'b0;
      adc_dat_a = '0;
      adc_dat_b = '0;
      sys_req   = '0;
      exp_in    = '0;
      for (int i = 0; i < 5; i++) begin
         hk_model[i] = '0;
      end
      repeat (8) @(posedge adc_clk);
      #1;
      arst_n_i = 1'b1;
      repeat (4) @(posedge adc_clk);     // let the reset sync release

      // --------------------
      // reset state and id word
      queue_check("rst led_o", '0, 32'(led));
      queue_check("rst exp_dir_o", '0, 32'(exp_dir));
      queue_check("rst exp_out_o", '0, 32'(exp_out));
      bus_read(rgn_addr(RGN_HK, HK_ID_OFS), rdata, err);
      queue_check("id rdata", HK_ID, rdata);
      queue_check("id err", '0, 32'(err));

      // byte lane writes to hk registers
      repeat (20) begin
         idx   = $unsigned($random(seed)) % 5;
         wdata = $random(seed);
         sel   = 4'($random(seed));
         hk_model[idx] = 8'(lane_merge(32'(hk_model[idx]), wdata, sel));
         bus_write(rgn_addr(RGN_HK, hk_reg_ofs(idx)), wdata, sel, err);
         queue_check("hk write err", '0, 32'(err));
         bus_read(rgn_addr(RGN_HK, hk_reg_ofs(idx)), rdata, err);
         queue_check($sformatf("hk reg %0d readback", idx), 32'(hk_model[idx]), rdata);
         check_hk_outputs();
      end

      // expansion inputs through the synchronizer
      repeat (4) begin
         @(posedge adc_clk);
         #1;
         exp_in = exp_port_t'(16'($random(seed)));
         repeat (5) @(posedge adc_clk);
         bus_read(rgn_addr(RGN_HK, HK_PIN_OFS), rdata, err);
         queue_check("exp_in p", 32'(exp_in.p), rdata);
         bus_read(rgn_addr(RGN_HK, HK_NIN_OFS), rdata, err);
         queue_check("exp_in n", 32'(exp_in.n), rdata);
      end

      // --------------------
      // adc samples, all negate settings
      for (int n = 0; n < 4; n++) begin
         neg = 2'(n);
         bus_write(rgn_addr(RGN_FE, FE_NEG_OFS), 32'(neg), 4'hf, err);
         for (int k = 0; k < 6; k++) begin
            if (k == 0) begin
               raw_a = '0;                       // most negative code
               raw_b = '1;                       // most positive code
            end else if (k == 1) begin
               raw_a = '1;
               raw_b = '0;
            end else begin
               raw_a = ADC_W'($random(seed));
               raw_b = ADC_W'($random(seed));
            end
            @(posedge adc_clk);
            #1;
            adc_dat_a = raw_a;
            adc_dat_b = raw_b;
            repeat (6) @(posedge adc_clk);       // pipeline plus readback
            bus_read(rgn_addr(RGN_FE, FE_SMPA_OFS), rdata, err);
            queue_check($sformatf("smp a neg %0d raw %h", neg, raw_a),
                        ref_sample(raw_a, neg[0]), rdata);
            bus_read(rgn_addr(RGN_FE, FE_SMPB_OFS), rdata, err);
            queue_check($sformatf("smp b neg %0d raw %h", neg, raw_b),
                        ref_sample(raw_b, neg[1]), rdata);
         end
      end

      // unmapped regions and unknown offset
      for (int r = 2; r < NUM_REGIONS; r++) begin
         bus_read(rgn_addr(r, 8'($random(seed))), rdata, err);
         queue_check($sformatf("rgn %0d rdata", r), '0, rdata);
         queue_check($sformatf("rgn %0d read err", r), 32'd1, 32'(err));
         bus_write(rgn_addr(r, 8'h00), $random(seed), 4'hf, err);
         queue_check($sformatf("rgn %0d write err", r), 32'd1, 32'(err));
      end
      wdata = $random(seed);
      bus_write(rgn_addr(RGN_HK, 8'h40), wdata, 4'hf, err);
      queue_check("hk unknown write err", '0, 32'(err));
      bus_read(rgn_addr(RGN_HK, 8'h40), rdata, err);
      queue_check("hk unknown rdata", '0, rdata);
      queue_check("hk unknown read err", '0, 32'(err));
      for (int i = 0; i < 5; i++) begin
         bus_read(rgn_addr(RGN_HK, hk_reg_ofs(i)), rdata, err);
         queue_check($sformatf("hk reg %0d kept", i), 32'(hk_model[i]), rdata);
      end
      check_hk_outputs();

      // --------------------
      // drain pending checks, then report
      waited = 0;
      while (cmp_name_q.size() > 0 && waited < CMP_TIMEOUT) begin
         @(posedge adc_clk);
         #1;
         waited++;
      end
      if (cmp_name_q.size() > 0) begin
         err_cnt++;
         $display("compare process did not drain its pending checks");
      end
      $display("checks %0d errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* radar_adc_top.f */
+incdir+verif
logic/adc_rx_pkg.sv
logic/adc_frontend.sv
logic/sys_bus_decoder.sv
logic/housekeeping_regs.sv
logic/frontend_regs.sv
logic/radar_adc_top.sv
verif/tb_radar_adc_top.sv

/* Bender.yml */
package:
  name: radar_adc

sources:
  - logic/adc_rx_pkg.sv
  - logic/adc_frontend.sv
  - logic/sys_bus_decoder.sv
  - logic/housekeeping_regs.sv
  - logic/frontend_regs.sv
  - logic/radar_adc_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_radar_adc_top.sv
